//--- hw/axi_pkg.sv
`default_nettype none

package axi_pkg;

   // --------------------------------------------------------------------------
   // pcim channel geometry
   // --------------------------------------------------------------------------
   localparam int ADDR_W          = 32;
   localparam int DATA_W          = 64;
   localparam int STRB_W          = DATA_W / 8;
   localparam int ID_W            = 5;
   localparam int LEN_W           = 8;   // beats minus one
   localparam int BEAT_BYTES_LOG2 = 3;

   // one queued burst, AW or AR
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [ID_W-1:0]   id;
      logic [LEN_W-1:0]  len;
   } axi_cmd_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10   // beat outside the ram window
   } axi_resp_e;

endpackage

`default_nettype wire

//--- hw/host_mem_pkg.sv
`default_nettype none

package host_mem_pkg;

   // write engine, one burst at a time
   typedef enum logic [1:0] {
      W_IDLE,
      W_DATA,
      W_RESP
   } wr_state_e;

   // read engine, fetch then send per beat
   typedef enum logic [1:0] {
      R_IDLE,
      R_FETCH,
      R_SEND
   } rd_state_e;

endpackage

`default_nettype wire

//--- hw/mem_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wr_if #(
   parameter int MEM_AW = 6
) ();
   import axi_pkg::*;

   logic              en;     // commits on this edge
   logic [MEM_AW-1:0] idx;    // word index
   logic [DATA_W-1:0] data;
   logic [STRB_W-1:0] strb;

   modport ctrl (output en, output idx, output data, output strb);
   modport ram  (input en, input idx, input data, input strb);

endinterface

`default_nettype wire

//--- hw/rst_sync.sv
`timescale 1ns/1ps
`default_nettype none

module rst_sync (
   input  logic clk_out,
   input  logic rst_n_i,
   output logic sync_rst_n_o
);

   logic [4:0] sync_q;

   // async assert, release walks through five flops
   always_ff @(posedge clk_out or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[3:0], 1'b1};
      end
   end

   assign sync_rst_n_o = sync_q[4];

endmodule

`default_nettype wire

//--- hw/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
   parameter int CMD_DEPTH = 4
) (
   input  logic              clk_out,
   input  logic              sync_rst_n,
   input  logic              push_i,
   input  axi_pkg::axi_cmd_t push_cmd_i,
   output logic              full_o,
   input  logic              pop_i,
   output axi_pkg::axi_cmd_t head_o,
   output logic              empty_o
);
   import axi_pkg::*;

   localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNT_W = $clog2(CMD_DEPTH + 1);

   axi_cmd_t         mem_q [CMD_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic [CNT_W-1:0] count_nxt;
   logic             full_q;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      ptr_inc = (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign count_nxt = count_q + CNT_W'(push_i) - CNT_W'(pop_i);

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         full_q   <= 1'b1;   // no push taken until out of reset
      end else begin
         if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
         count_q <= count_nxt;
         full_q  <= (count_nxt == CNT_W'(CMD_DEPTH));
      end
   end

   always_ff @(posedge clk_out) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_cmd_i;
      end
   end

   assign head_o  = mem_q[rd_ptr_q];
   assign empty_o = (count_q == '0);
   assign full_o  = full_q;

   a_no_overflow: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      !(push_i && full_o));
   a_no_underflow: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      !(pop_i && empty_o));

endmodule

`default_nettype wire

//--- hw/pcim_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pcim_wr_ctrl #(
   parameter int MEM_AW = 6
) (
   input  logic                          clk_out,
   input  logic                          sync_rst_n,
   input  axi_pkg::axi_cmd_t             cmd_i,
   input  logic                          cmd_empty_i,
   output logic                          cmd_pop_o,
   input  logic [axi_pkg::DATA_W-1:0]    wdata_i,
   input  logic [axi_pkg::STRB_W-1:0]    wstrb_i,
   input  logic                          wlast_i,
   input  logic                          wvalid_i,
   output logic                          wready_o,
   output logic [axi_pkg::ID_W-1:0]      bid_o,
   output axi_pkg::axi_resp_e            bresp_o,
   output logic                          bvalid_o,
   input  logic                          bready_i,
   mem_wr_if.ctrl                        mem_wr
);
   import axi_pkg::*;
   import host_mem_pkg::*;

   localparam int WIN_LSB = BEAT_BYTES_LOG2 + MEM_AW;

   wr_state_e         state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]  beat_q;
   logic              err_q;    // sticky over the burst
   logic              beat_acc;
   logic              last_beat;
   logic              in_win;

   assign wready_o  = (state_q == W_DATA);
   assign beat_acc  = wvalid_i & wready_o;
   assign last_beat = (beat_q == cmd_i.len);
   assign in_win    = (addr_q[ADDR_W-1:WIN_LSB] == '0);

   // --------------------------------------------------------------------------
   // ram write port
   // --------------------------------------------------------------------------
   assign mem_wr.en   = beat_acc & in_win;   // out of window beats are dropped
   assign mem_wr.idx  = addr_q[BEAT_BYTES_LOG2 +: MEM_AW];
   assign mem_wr.data = wdata_i;
   assign mem_wr.strb = wstrb_i;

   // head stays in the fifo until B completes
   assign bvalid_o  = (state_q == W_RESP);
   assign bid_o     = cmd_i.id;
   assign bresp_o   = err_q ? SLVERR : OKAY;
   assign cmd_pop_o = bvalid_o & bready_i;

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q <= W_IDLE;
         beat_q  <= '0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            W_IDLE: begin
               if (!cmd_empty_i) begin
                  beat_q  <= '0;
                  err_q   <= 1'b0;
                  state_q <= W_DATA;
               end
            end
            W_DATA: begin
               if (beat_acc) begin
                  beat_q <= beat_q + 1'b1;
                  err_q  <= err_q | ~in_win;
                  if (last_beat) state_q <= W_RESP;
               end
            end
            W_RESP: begin
               if (bready_i) state_q <= W_IDLE;
            end
            default: state_q <= W_IDLE;
         endcase
      end
   end

   // beat address, incr burst
   always_ff @(posedge clk_out) begin
      if (state_q == W_IDLE && !cmd_empty_i) begin
         addr_q <= cmd_i.addr;
      end else if (beat_acc) begin
         addr_q <= addr_q + ADDR_W'(STRB_W);
      end
   end

   a_b_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o) && $stable(bresp_o));
   a_wlast_pos: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      beat_acc |-> (wlast_i == last_beat));

endmodule

`default_nettype wire

//--- hw/pcim_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pcim_rd_ctrl #(
   parameter int MEM_AW = 6
) (
   input  logic                          clk_out,
   input  logic                          sync_rst_n,
   input  axi_pkg::axi_cmd_t             cmd_i,
   input  logic                          cmd_empty_i,
   output logic                          cmd_pop_o,
   output logic                          rd_en_o,
   output logic [MEM_AW-1:0]             rd_idx_o,
   input  logic [axi_pkg::DATA_W-1:0]    rd_data_i,
   output logic [axi_pkg::ID_W-1:0]      rid_o,
   output logic [axi_pkg::DATA_W-1:0]    rdata_o,
   output axi_pkg::axi_resp_e            rresp_o,
   output logic                          rlast_o,
   output logic                          rvalid_o,
   input  logic                          rready_i
);
   import axi_pkg::*;
   import host_mem_pkg::*;

   localparam int WIN_LSB = BEAT_BYTES_LOG2 + MEM_AW;

   rd_state_e         state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]  beat_q;
   logic              oob_q;    // current beat outside window
   logic              last_q;
   logic              in_win;
   logic              last_beat;
   logic              r_hs;

   assign in_win    = (addr_q[ADDR_W-1:WIN_LSB] == '0);
   assign last_beat = (beat_q == cmd_i.len);

   // one fetch per beat, ram answers next cycle
   assign rd_en_o  = (state_q == R_FETCH) & in_win;
   assign rd_idx_o = addr_q[BEAT_BYTES_LOG2 +: MEM_AW];

   // --------------------------------------------------------------------------
   // R channel
   // --------------------------------------------------------------------------
   assign rvalid_o  = (state_q == R_SEND);
   assign r_hs      = rvalid_o & rready_i;
   assign rid_o     = cmd_i.id;
   assign rresp_o   = oob_q ? SLVERR : OKAY;
   assign rdata_o   = oob_q ? '0 : rd_data_i;   // ram output only moves on rd_en
   assign rlast_o   = last_q;
   assign cmd_pop_o = r_hs & last_q;

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q <= R_IDLE;
         beat_q  <= '0;
         oob_q   <= 1'b0;
         last_q  <= 1'b0;
      end else begin
         case (state_q)
            R_IDLE: begin
               if (!cmd_empty_i) begin
                  beat_q  <= '0;
                  state_q <= R_FETCH;
               end
            end
            R_FETCH: begin
               oob_q   <= ~in_win;
               last_q  <= last_beat;
               state_q <= R_SEND;
            end
            R_SEND: begin
               if (r_hs) begin
                  last_q <= 1'b0;
                  if (last_q) begin
                     state_q <= R_IDLE;
                  end else begin
                     beat_q  <= beat_q + 1'b1;
                     state_q <= R_FETCH;
                  end
               end
            end
            default: state_q <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (state_q == R_IDLE && !cmd_empty_i) begin
         addr_q <= cmd_i.addr;
      end else if (r_hs) begin
         addr_q <= addr_q + ADDR_W'(STRB_W);   // next beat
      end
   end

   // payload includes the ram read register
   a_r_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      rvalid_o && !rready_i |=>
         rvalid_o && $stable({rid_o, rdata_o, rresp_o, rlast_o}));

endmodule

`default_nettype wire

//--- hw/host_mem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module host_mem_ram #(
   parameter int MEM_AW = 6
) (
   input  logic                       clk_out,
   mem_wr_if.ram                      wr,
   input  logic                       rd_en_i,
   input  logic [MEM_AW-1:0]          rd_idx_i,
   output logic [axi_pkg::DATA_W-1:0] rd_data_o
);
   import axi_pkg::*;

   logic [DATA_W-1:0] mem_q [2**MEM_AW];

   // byte lanes under strobe
   always_ff @(posedge clk_out) begin
      if (wr.en) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wr.strb[b]) begin
               mem_q[wr.idx][b*8 +: 8] <= wr.data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_out) begin
      if (rd_en_i) begin
         rd_data_o <= mem_q[rd_idx_i];   // held between fetches
      end
   end

endmodule

`default_nettype wire

//--- hw/host_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_mem_top #(
   parameter int MEM_AW    = 6,   // 64 words of 8 bytes
   parameter int CMD_DEPTH = 4
) (
   input  logic                       clk_out,
   input  logic                       rst_n_i,

   input  logic [axi_pkg::ID_W-1:0]   awid_i,
   input  logic [axi_pkg::ADDR_W-1:0] awaddr_i,
   input  logic [axi_pkg::LEN_W-1:0]  awlen_i,
   input  logic                       awvalid_i,
   output logic                       awready_o,

   input  logic [axi_pkg::DATA_W-1:0] wdata_i,
   input  logic [axi_pkg::STRB_W-1:0] wstrb_i,
   input  logic                       wlast_i,
   input  logic                       wvalid_i,
   output logic                       wready_o,

   output logic [axi_pkg::ID_W-1:0]   bid_o,
   output axi_pkg::axi_resp_e         bresp_o,
   output logic                       bvalid_o,
   input  logic                       bready_i,

   input  logic [axi_pkg::ID_W-1:0]   arid_i,
   input  logic [axi_pkg::ADDR_W-1:0] araddr_i,
   input  logic [axi_pkg::LEN_W-1:0]  arlen_i,
   input  logic                       arvalid_i,
   output logic                       arready_o,

   output logic [axi_pkg::ID_W-1:0]   rid_o,
   output logic [axi_pkg::DATA_W-1:0] rdata_o,
   output axi_pkg::axi_resp_e         rresp_o,
   output logic                       rlast_o,
   output logic                       rvalid_o,
   input  logic                       rready_i
);
   import axi_pkg::*;

   logic              sync_rst_n;
   axi_cmd_t          aw_cmd;
   axi_cmd_t          ar_cmd;
   axi_cmd_t          wr_head;
   axi_cmd_t          rd_head;
   logic              aw_full;
   logic              ar_full;
   logic              wr_empty;
   logic              rd_empty;
   logic              wr_pop;
   logic              rd_pop;
   logic              rd_en;
   logic [MEM_AW-1:0] rd_idx;
   logic [DATA_W-1:0] rd_data;

   mem_wr_if #(.MEM_AW(MEM_AW)) mem_wr ();

   rst_sync u_rst_sync (
      .clk_out      (clk_out),
      .rst_n_i      (rst_n_i),
      .sync_rst_n_o (sync_rst_n)
   );

   // --------------------------------------------------------------------------
   // address queues
   // --------------------------------------------------------------------------
   assign aw_cmd    = '{addr: awaddr_i, id: awid_i, len: awlen_i};
   assign ar_cmd    = '{addr: araddr_i, id: arid_i, len: arlen_i};
   assign awready_o = ~aw_full;
   assign arready_o = ~ar_full;

   cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) u_aw_fifo (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .push_i     (awvalid_i & awready_o),
      .push_cmd_i (aw_cmd),
      .full_o     (aw_full),
      .pop_i      (wr_pop),
      .head_o     (wr_head),
      .empty_o    (wr_empty)
   );

   cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) u_ar_fifo (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .push_i     (arvalid_i & arready_o),
      .push_cmd_i (ar_cmd),
      .full_o     (ar_full),
      .pop_i      (rd_pop),
      .head_o     (rd_head),
      .empty_o    (rd_empty)
   );

   // --------------------------------------------------------------------------
   // burst engines and host ram
   // --------------------------------------------------------------------------
   pcim_wr_ctrl #(.MEM_AW(MEM_AW)) u_wr_ctrl (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .cmd_i       (wr_head),
      .cmd_empty_i (wr_empty),
      .cmd_pop_o   (wr_pop),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .wlast_i     (wlast_i),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .bid_o       (bid_o),
      .bresp_o     (bresp_o),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .mem_wr      (mem_wr.ctrl)
   );

   pcim_rd_ctrl #(.MEM_AW(MEM_AW)) u_rd_ctrl (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .cmd_i       (rd_head),
      .cmd_empty_i (rd_empty),
      .cmd_pop_o   (rd_pop),
      .rd_en_o     (rd_en),
      .rd_idx_o    (rd_idx),
      .rd_data_i   (rd_data),
      .rid_o       (rid_o),
      .rdata_o     (rdata_o),
      .rresp_o     (rresp_o),
      .rlast_o     (rlast_o),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i)
   );

   host_mem_ram #(.MEM_AW(MEM_AW)) u_ram (
      .clk_out   (clk_out),
      .wr        (mem_wr.ram),
      .rd_en_i   (rd_en),
      .rd_idx_i  (rd_idx),
      .rd_data_o (rd_data)
   );

endmodule

`default_nettype wire

//--- tests/tb_host_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_mem;
   import axi_pkg::*;

   localparam int MEM_AW    = 6;
   localparam int CMD_DEPTH = 4;
   localparam int WIN_WORDS = 1 << MEM_AW;
   localparam int WIN_BYTES = STRB_W * WIN_WORDS;
   localparam int CLK_HALF  = 20;
   localparam int DRIVE_DLY = 2;
   localparam int TIMEOUT   = 200;   // cycles per wait

   logic              clk_out;
   logic              rst_n_i;
   logic [ID_W-1:0]   awid_i;
   logic [ADDR_W-1:0] awaddr_i;
   logic [LEN_W-1:0]  awlen_i;
   logic              awvalid_i;
   logic              awready_o;
   logic [DATA_W-1:0] wdata_i;
   logic [STRB_W-1:0] wstrb_i;
   logic              wlast_i;
   logic              wvalid_i;
   logic              wready_o;
   logic [ID_W-1:0]   bid_o;
   axi_resp_e         bresp_o;
   logic              bvalid_o;
   logic              bready_i;
   logic [ID_W-1:0]   arid_i;
   logic [ADDR_W-1:0] araddr_i;
   logic [LEN_W-1:0]  arlen_i;
   logic              arvalid_i;
   logic              arready_o;
   logic [ID_W-1:0]   rid_o;
   logic [DATA_W-1:0] rdata_o;
   axi_resp_e         rresp_o;
   logic              rlast_o;
   logic              rvalid_o;
   logic              rready_i;

   logic [7:0]  model_mem [WIN_BYTES];   // byte image of the window
   logic [31:0] lfsr_q;

   host_mem_top #(.MEM_AW(MEM_AW), .CMD_DEPTH(CMD_DEPTH)) UUT (.*);

   initial begin
      clk_out = 1'b0;
      forever #CLK_HALF clk_out = ~clk_out;
   end

   // --------------------------------------------------------------------------
   // random source, reference model and compares
   // --------------------------------------------------------------------------
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
         v = {v[62:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic logic in_window(input logic [ADDR_W-1:0] addr);
      return addr < ADDR_W'(WIN_BYTES);
   endfunction

   function automatic logic [DATA_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] w;
      for (int b = 0; b < STRB_W; b++) begin
         w[b*8 +: 8] = model_mem[addr + b];
      end
      return w;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_id(input string name, input logic [ID_W-1:0] got,
                           input logic [ID_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_idle(input logic in_reset);
      check_flag("bvalid_o", bvalid_o, 1'b0);
      check_flag("rvalid_o", rvalid_o, 1'b0);
      check_flag("wready_o", wready_o, 1'b0);
      check_flag("rlast_o", rlast_o, 1'b0);
      if (in_reset) begin
         check_flag("awready_o", awready_o, 1'b0);
         check_flag("arready_o", arready_o, 1'b0);
      end
   endtask

   // --------------------------------------------------------------------------
   // channel drivers start and end just after a rising edge
   // --------------------------------------------------------------------------
   task automatic tick();
      @(posedge clk_out);
      #DRIVE_DLY;
   endtask

   task automatic send_aw(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                          input logic [LEN_W-1:0] len);
      int cnt;
      cnt = 0;
      awid_i    = id;
      awaddr_i  = addr;
      awlen_i   = len;
      awvalid_i = 1'b1;
      while (!awready_o) begin
         tick();
         cnt++;
         if (cnt > TIMEOUT) abort_run("awready stayed low, write address never taken");
      end
      tick();
      awvalid_i = 1'b0;
   endtask

   task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                          input logic [LEN_W-1:0] len);
      int cnt;
      cnt = 0;
      arid_i    = id;
      araddr_i  = addr;
      arlen_i   = len;
      arvalid_i = 1'b1;
      while (!arready_o) begin
         tick();
         cnt++;
         if (cnt > TIMEOUT) abort_run("arready stayed low, read address never taken");
      end
      tick();
      arvalid_i = 1'b0;
   endtask

   // each beat also updates the model and sets oob when it misses the window
   task automatic send_w_burst(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                               input logic full_strb, output logic oob);
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      logic [STRB_W-1:0] s;
      int                cnt;
      oob = 1'b0;
      for (int b = 0; b <= int'(len); b++) begin
         a = addr + ADDR_W'(b * STRB_W);
         d = rand_bits(DATA_W);
         s = full_strb ? '1 : STRB_W'(rand_bits(STRB_W));
         wdata_i  = d;
         wstrb_i  = s;
         wlast_i  = (b == int'(len));
         wvalid_i = 1'b1;
         cnt = 0;
         while (!wready_o) begin
            tick();
            cnt++;
            if (cnt > TIMEOUT) abort_run("wready stayed low, write beat never taken");
         end
         tick();
         wvalid_i = 1'b0;
         wlast_i  = 1'b0;
         if (in_window(a)) begin
            for (int k = 0; k < STRB_W; k++) begin
               if (s[k]) model_mem[a + k] = d[k*8 +: 8];
            end
         end else begin
            oob = 1'b1;
         end
         if (rand_bits(2) == 0) tick();   // idle gap on W
      end
   endtask

   task automatic wait_b(input logic [ID_W-1:0] exp_id, input axi_resp_e exp_resp);
      int cnt;
      int stall;
      cnt   = 0;
      stall = int'(rand_bits(2));
      while (!bvalid_o) begin
         tick();
         cnt++;
         if (cnt > TIMEOUT) abort_run("bvalid never rose after the last write beat");
      end
      repeat (stall) begin
         tick();
         check_flag("bvalid_o", bvalid_o, 1'b1);   // held while bready low
         check_flag("wready_o", wready_o, 1'b0);
      end
      check_id("bid_o", bid_o, exp_id);
      check_resp("bresp_o", bresp_o, exp_resp);
      bready_i = 1'b1;
      tick();
      bready_i = 1'b0;
   endtask

   task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input logic [LEN_W-1:0] len, input logic full_strb);
      logic oob;
      send_aw(id, addr, len);
      send_w_burst(addr, len, full_strb, oob);
      wait_b(id, oob ? SLVERR : OKAY);
   endtask

   // random rready on every cycle
   task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input logic [LEN_W-1:0] len);
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] exp_data;
      axi_resp_e         exp_resp;
      int                cnt;
      send_ar(id, addr, len);
      for (int b = 0; b <= int'(len); b++) begin
         a        = addr + ADDR_W'(b * STRB_W);
         exp_data = in_window(a) ? model_word(a) : '0;
         exp_resp = in_window(a) ? OKAY : SLVERR;
         cnt      = 0;
         rready_i = (rand_bits(1) != 0);
         while (!(rvalid_o && rready_i)) begin
            tick();
            rready_i = (rand_bits(1) != 0);
            cnt++;
            if (cnt > TIMEOUT) abort_run("no read beat delivered before the timeout");
         end
         check_id("rid_o", rid_o, id);
         check_data("rdata_o", rdata_o, exp_data);
         check_resp("rresp_o", rresp_o, exp_resp);
         check_flag("rlast_o", rlast_o, b == int'(len));
         tick();
      end
      rready_i = 1'b0;
   endtask

   // --------------------------------------------------------------------------
   // test sequence
   // --------------------------------------------------------------------------
   initial begin
      logic             oob;
      logic [ID_W-1:0]  id;
      logic [LEN_W-1:0] len;
      int               idx;
      int               cnt;
      lfsr_q    = 32'h287d_4377;
      rst_n_i   = 1'b0;
      awid_i    = '0;
      awaddr_i  = '0;
      awlen_i   = '0;
      awvalid_i = 1'b0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wlast_i   = 1'b0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b0;
      arid_i    = '0;
      araddr_i  = '0;
      arlen_i   = '0;
      arvalid_i = 1'b0;
      rready_i  = 1'b0;

      for (int c = 0; c < 2; c++) begin
         tick();
         check_idle(1'b1);
      end
      rst_n_i = 1'b1;

      // ready flags rise once the synchronizer releases
      cnt = 0;
      while (!(awready_o && arready_o)) begin
         check_idle(1'b0);
         tick();
         cnt++;
         if (cnt > TIMEOUT) abort_run("awready and arready never rose after reset");
      end
      repeat (10) begin
         tick();
         check_idle(1'b0);
      end

      // four queued full bursts cover the window
      for (int i = 0; i < 4; i++) begin
         send_aw(ID_W'(i + 1), ADDR_W'(i * 128), LEN_W'(15));
      end
      check_flag("awready_o", awready_o, 1'b0);   // queue of four is full
      for (int i = 0; i < 4; i++) begin
         send_w_burst(ADDR_W'(i * 128), LEN_W'(15), 1'b1, oob);
         wait_b(ID_W'(i + 1), OKAY);
      end

      repeat (40) begin
         id  = ID_W'(rand_bits(ID_W));
         len = LEN_W'(rand_bits(2));
         idx = int'(rand_bits(MEM_AW));
         if (idx > WIN_WORDS - 1 - int'(len)) idx = WIN_WORDS - 1 - int'(len);
         write_burst(id, ADDR_W'(idx * STRB_W), len, 1'b0);
         read_burst(ID_W'(rand_bits(ID_W)), ADDR_W'(idx * STRB_W), len);
      end

      // crossing the top of the window, then fully outside
      write_burst(5'd7, ADDR_W'((WIN_WORDS - 2) * STRB_W), LEN_W'(3), 1'b0);
      write_burst(5'd8, 32'h0000_1000, LEN_W'(2), 1'b0);
      write_burst(5'd9, 32'h8000_0010, LEN_W'(0), 1'b0);
      read_burst(5'd10, ADDR_W'((WIN_WORDS - 2) * STRB_W), LEN_W'(3));
      read_burst(5'd11, 32'h0000_1000, LEN_W'(2));
      read_burst(5'd12, 32'h8000_0010, LEN_W'(0));

      // whole window plus a crossing read
      for (int i = 0; i < 4; i++) begin
         read_burst(ID_W'(16 + i), ADDR_W'(i * 128), LEN_W'(15));
      end
      read_burst(5'd31, ADDR_W'((WIN_WORDS - 8) * STRB_W), LEN_W'(15));

      repeat (4) begin
         tick();
         check_idle(1'b0);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
hw/axi_pkg.sv
hw/host_mem_pkg.sv
hw/mem_wr_if.sv
hw/rst_sync.sv
hw/cmd_fifo.sv
hw/pcim_wr_ctrl.sv
hw/pcim_rd_ctrl.sv
hw/host_mem_ram.sv
hw/host_mem_top.sv
tests/tb_host_mem.sv

//--- Bender.yml
package:
  name: host_mem

sources:
  # packages first, then the design bottom up
  - files:
      - hw/axi_pkg.sv
      - hw/host_mem_pkg.sv
      - hw/mem_wr_if.sv
      - hw/rst_sync.sv
      - hw/cmd_fifo.sv
      - hw/pcim_wr_ctrl.sv
      - hw/pcim_rd_ctrl.sv
      - hw/host_mem_ram.sv
      - hw/host_mem_top.sv

  - target: test
    files:
      - tests/tb_host_mem.sv
